/* verilog.f */
logic/az_pkg.sv
logic/settle_timer.sv
logic/az_sequencer.sv
logic/adc_mock.sv
logic/az_result.sv
logic/az_top.sv
bench/az_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# the run passes only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module az_tb -f verilog.f -o az_sim \
  && ./obj_dir/az_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

/* bench/az_tb.sv */
// testbench for the auto-zero front end
// levels come from a seeded $random and stay fixed for each measurement
// expected results come from a reference model of the zero correction
// the watchdog bounds the whole run, so the waits below have no limit of their own

`timescale 1ns/10ps

module az_tb import az_pkg::*; ();

  localparam int N_AZ     = 8;
  localparam int N_RAW    = 8;
  localparam int SETTLE   = 3;
  localparam int SD_MAIN  = 5;
  localparam int SD_SHORT = 2;
  localparam int SD_LONG  = 9;

  // all results of the run, tail pairs and quiet windows counted as results
  localparam int PLANNED    = N_AZ + N_RAW + 16;
  localparam int PHASE_CYC  = SETTLE + SD_LONG + 6;
  localparam int TIMEOUT_NS = PLANNED * PHASE_CYC * 2 * 4 * 2;

  logic                      clk;
  logic                      reset;
  az_cfg_t                   cfg;
  logic                      run;
  logic                      abort;
  logic signed [LEVEL_W-1:0] signal_level;
  logic signed [LEVEL_W-1:0] zero_level;
  az_result_t                result;
  logic                      result_valid;
  az_phase_t                 mux_sel;
  logic [5:0]                monitor;

  integer    seed;
  int        checks = 0;
  int        errors = 0;
  int        result_checks = 0;
  int        result_errors = 0;
  int        results_seen = 0;
  int        trig_count = 0;
  int        tests_done = 0;
  az_phase_t trig_phases[$];
  az_phase_t mon_phases[$];

  az_top #(
    .LEVEL_W  (LEVEL_W),
    .RESULT_W (RESULT_W)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .cfg          (cfg),
    .run          (run),
    .abort        (abort),
    .signal_level (signal_level),
    .zero_level   (zero_level),
    .result       (result),
    .result_valid (result_valid),
    .mux_sel      (mux_sel),
    .monitor      (monitor)
  );

  // 4 ns clock
  initial
    clk = 1'b0;
  always #2 clk = ~clk;

  // reference model, sign extension done by hand
  function automatic az_result_t expected_result(
    input logic signed [LEVEL_W-1:0] sig,
    input logic signed [LEVEL_W-1:0] zero,
    input logic                      az_on
  );
    az_result_t                 exp_r;
    logic signed [RESULT_W-1:0] sig_ext;
    logic signed [RESULT_W-1:0] zero_ext;
    sig_ext  = {{(RESULT_W-LEVEL_W){sig[LEVEL_W-1]}}, sig};
    zero_ext = {{(RESULT_W-LEVEL_W){zero[LEVEL_W-1]}}, zero};
    exp_r.az = az_on;
    if (az_on)
      exp_r.value = sig_ext - zero_ext;
    else
      exp_r.value = sig_ext;
    return exp_r;
  endfunction

  task automatic check_result(input string name, input az_result_t got, input az_result_t exp);
    result_checks++;
    if (got !== exp)
    begin
      result_errors++;
      $display("mismatch at %0d ns: %s got value %0d az %0b, expected value %0d az %0b",
               $time, name, got.value, got.az, exp.value, exp.az);
    end
  endtask

  task automatic check_phase(input string name, input az_phase_t got, input az_phase_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s got %s, expected %s",
               $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // every result strobe is checked against the levels on the inputs
  always @(negedge clk)
  begin
    if (!reset && result_valid)
    begin
      results_seen++;
      check_result("result", result,
                   expected_result(signal_level, zero_level, cfg.az_enable));
    end
  end

  // log the selector setting at every converter trigger
  // both the mux_sel port and its copy in monitor bit 2
  always @(negedge clk)
  begin
    if (!reset && monitor[0])
    begin
      trig_count++;
      trig_phases.push_back(mux_sel);
      mon_phases.push_back(az_phase_t'(monitor[2]));
    end
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("error: watchdog stopped the run at %0d ns, the DUT stopped responding", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  // inputs change 1 ns after the rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic new_levels();
    signal_level = LEVEL_W'($random(seed));
    zero_level   = LEVEL_W'($random(seed));
  endtask

  task automatic set_cfg(input logic az_on, input int sd);
    cfg.az_enable       = az_on;
    cfg.sample_duration = sd;
    cfg.settle_cycles   = 16'(SETTLE);
  endtask

  // drop run and wait until the sequencer is back in idle
  task automatic stop_run();
    run = 1'b0;
    wait_cycle();
    while (monitor[5:3] != 3'd0)
      wait_cycle();
  endtask

  // measure n results, new levels right after each one
  task automatic run_measurements(input logic az_on, input int sd, input int n);
    int target;
    int seen;
    set_cfg(az_on, sd);
    new_levels();
    target = results_seen + n;
    run    = 1'b1;
    while (results_seen < target)
    begin
      seen = results_seen;
      wait_cycle();
      if (results_seen != seen)
        new_levels();
      else if (!az_on)
        zero_level = LEVEL_W'($random(seed));
    end
  endtask

  // short run that checks the selector at each trigger
  task automatic phase_order_run(input logic az_on);
    int        trig_base;
    int        res_base;
    int        n_res;
    az_phase_t exp_ph;
    trig_base = trig_phases.size();
    res_base  = results_seen;
    run_measurements(az_on, SD_MAIN, 2);
    stop_run();
    n_res = results_seen - res_base;
    if (trig_phases.size() - trig_base != (az_on ? 2 : 1) * n_res)
      report_error($sformatf("%0d triggers were seen for %0d results",
                             trig_phases.size() - trig_base, n_res));
    for (int i = trig_base; i < trig_phases.size(); i++)
    begin
      // az mode alternates zero and signal, raw mode is signal only
      if (az_on && (i - trig_base) % 2 == 0)
        exp_ph = PHASE_ZERO;
      else
        exp_ph = PHASE_SIGNAL;
      check_phase("mux_sel at trigger", trig_phases[i], exp_ph);
      check_phase("monitor[2] at trigger", mon_phases[i], exp_ph);
    end
  endtask

  // abort right after the signal trigger, while the converter is busy
  task automatic abort_run();
    int trig_base;
    int res_base;
    set_cfg(1'b1, SD_MAIN);
    new_levels();
    run = 1'b1;
    @(negedge clk);
    while (!(monitor[0] && mux_sel == PHASE_SIGNAL))
      @(negedge clk);
    wait_cycle();
    if (monitor[1])
      report_error("converter valid was already high when the abort was applied");
    abort = 1'b1;
    new_levels();
    trig_base = trig_phases.size();
    res_base  = results_seen;
    wait_cycle();
    abort = 1'b0;
    while (results_seen == res_base)
      wait_cycle();
    // the first result after the abort needs a fresh zero and signal pair
    if (trig_phases.size() - trig_base != 2)
      report_error($sformatf("result came %0d triggers after the abort instead of 2",
                             trig_phases.size() - trig_base));
    else
    begin
      check_phase("mux_sel after abort", trig_phases[trig_base], PHASE_ZERO);
      check_phase("mux_sel after abort", trig_phases[trig_base + 1], PHASE_SIGNAL);
    end
    stop_run();
  endtask

  // drop run in the middle of a pair, then watch for late results
  task automatic stop_check();
    int res_base;
    bit late_seen;
    set_cfg(1'b1, SD_MAIN);
    new_levels();
    run      = 1'b1;
    res_base = results_seen;
    while (results_seen == res_base)
      wait_cycle();
    @(negedge clk);
    while (!monitor[0])
      @(negedge clk);
    wait_cycle();
    run       = 1'b0;
    res_base  = results_seen;
    late_seen = 1'b0;
    // one pair in flight plus a long quiet window
    repeat (6 * PHASE_CYC)
    begin
      wait_cycle();
      if (results_seen - res_base > 1 && !late_seen)
      begin
        late_seen = 1'b1;
        report_error("a second result arrived after run had gone low");
      end
    end
    if (monitor[5:3] != 3'd0)
      report_error("the sequencer did not return to idle after run went low");
  endtask

  // converter valid must rise at edge T + sample_duration + 2
  task automatic conversion_length(input int sd);
    int count;
    set_cfg(1'b0, sd);
    new_levels();
    run = 1'b1;
    @(negedge clk);
    while (!monitor[0])
      @(negedge clk);
    count = 0;
    do
    begin
      @(negedge clk);
      count++;
    end
    while (!monitor[1]);
    // edge T ends the trigger cycle, the rise edge starts the first valid cycle
    check_latency("monitor[1] rise edge after trigger", count - 1, sd + 2);
    wait_cycle();
    stop_run();
  endtask

  task automatic report_test(input string title, input int err_base);
    int n;
    n = errors + result_errors - err_base;
    tests_done++;
    if (n == 0)
      $display("test %0d %s: ok", tests_done, title);
    else
      $display("test %0d %s: failed with %0d errors", tests_done, title, n);
  endtask

  initial
  begin
    int err_base;
    seed         = 32'h8ea1_5b92;
    reset        = 1'b1;
    run          = 1'b0;
    abort        = 1'b0;
    cfg          = '0;
    signal_level = '0;
    zero_level   = '0;
    repeat (4)
      @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycle();

    err_base = errors + result_errors;
    run_measurements(1'b1, SD_MAIN, N_AZ);
    stop_run();
    report_test("auto-zero correction", err_base);

    err_base = errors + result_errors;
    run_measurements(1'b0, SD_MAIN, N_RAW);
    stop_run();
    report_test("raw mode", err_base);

    err_base = errors + result_errors;
    phase_order_run(1'b1);
    phase_order_run(1'b0);
    report_test("phase order", err_base);

    err_base = errors + result_errors;
    abort_run();
    report_test("abort mid-conversion", err_base);

    err_base = errors + result_errors;
    stop_check();
    report_test("stop on run low", err_base);

    err_base = errors + result_errors;
    conversion_length(SD_SHORT);
    conversion_length(SD_LONG);
    report_test("conversion length", err_base);

    $display("summary: %0d tests, %0d checks, %0d errors, %0d results, %0d triggers",
             tests_done, checks + result_checks, errors + result_errors,
             results_seen, trig_count);
    if (errors + result_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* logic/az_top.sv */
// measurement front end with auto-zero
// cfg must be held static while run is high
// result_valid is a strobe with no back-pressure, the consumer must take it
// monitor is {state code, mux_sel, converter valid, trigger}

`timescale 1ns/10ps

module az_top import az_pkg::*; #(
  parameter int LEVEL_W  = az_pkg::LEVEL_W,
  parameter int RESULT_W = az_pkg::RESULT_W
) (
  input  logic                      clk,
  input  logic                      reset,
  input  az_cfg_t                   cfg,
  input  logic                      run,
  input  logic                      abort,
  input  logic signed [LEVEL_W-1:0] signal_level,
  input  logic signed [LEVEL_W-1:0] zero_level,
  output az_result_t                result,
  output logic                      result_valid,
  output az_phase_t                 mux_sel,
  output logic [5:0]                monitor
);

  logic         settle_start;
  logic         settle_done;
  logic         adc_trig;
  logic         adc_valid;
  logic         reading_take;
  logic [2:0]   state_code;
  adc_reading_t reading;

  // phase ordering, triggers and aborts
  az_sequencer seq_i (
    .clk          (clk),
    .reset        (reset),
    .cfg          (cfg),
    .run          (run),
    .abort        (abort),
    .settle_done  (settle_done),
    .adc_valid    (adc_valid),
    .settle_start (settle_start),
    .adc_trig     (adc_trig),
    .phase        (mux_sel),
    .reading_take (reading_take),
    .state_code   (state_code)
  );

  // input settling after each selector change
  settle_timer timer_i (
    .clk    (clk),
    .reset  (reset),
    .start  (settle_start),
    .cycles (cfg.settle_cycles),
    .done   (settle_done)
  );

  // converter, selector follows the sequencer phase
  adc_mock #(
    .LEVEL_W (LEVEL_W)
  ) adc_i (
    .clk             (clk),
    .reset           (reset),
    .trig            (adc_trig),
    .sample_duration (cfg.sample_duration),
    .sel             (mux_sel),
    .signal_level    (signal_level),
    .zero_level      (zero_level),
    .valid           (adc_valid),
    .reading         (reading)
  );

  // zero subtraction and result strobe
  az_result #(
    .LEVEL_W  (LEVEL_W),
    .RESULT_W (RESULT_W)
  ) result_i (
    .clk          (clk),
    .reset        (reset),
    .take         (reading_take),
    .reading      (reading),
    .az_enable    (cfg.az_enable),
    .abort        (abort),
    .result       (result),
    .result_valid (result_valid)
  );

  // debug view of the conversion handshake and sequencer
  assign monitor = {state_code, mux_sel, adc_valid, adc_trig};

endmodule

/* logic/az_result.sv */
// result stage, keeps the last zero reading and corrects the signal
// az mode gives signal minus zero, raw mode the sign-extended signal
// in az mode a signal reading without a stored zero gives no result
// result_valid is a single strobe one clock after the take

`timescale 1ns/10ps

module az_result import az_pkg::*; #(
  parameter int LEVEL_W  = az_pkg::LEVEL_W,
  parameter int RESULT_W = az_pkg::RESULT_W
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         take,
  input  adc_reading_t reading,
  input  logic         az_enable,
  input  logic         abort,
  output az_result_t   result,
  output logic         result_valid
);

  // width of the value field in the result
  localparam int OUT_W = $bits(az_result_t) - 1;

  logic signed [LEVEL_W-1:0]  level_in;
  logic signed [LEVEL_W-1:0]  zero_q;
  logic                       zero_valid;
  logic signed [RESULT_W-1:0] level_ext;
  logic signed [RESULT_W-1:0] corrected;

  assign level_in  = LEVEL_W'(reading.value);
  assign level_ext = RESULT_W'(level_in);

  // the extra result bits keep the difference from overflowing
  assign corrected = level_ext - RESULT_W'(zero_q);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      zero_q       <= '0;
      zero_valid   <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= 1'b0;

      if (abort)
      begin
        // stored zero no longer matches the restarted pair
        zero_valid <= 1'b0;
      end
      else if (take)
      begin
        if (reading.phase == PHASE_ZERO)
        begin
          zero_q     <= level_in;
          zero_valid <= 1'b1;
        end
        else if (!az_enable || zero_valid)
        begin
          result_valid <= 1'b1;
        end
      end
    end
  end

  // result value, only meaningful with result_valid
  always_ff @(posedge clk)
  begin
    if (take && reading.phase == PHASE_SIGNAL)
    begin
      result.value <= OUT_W'(az_enable ? corrected : level_ext);
      result.az    <= az_enable;
    end
  end

endmodule

/* logic/adc_mock.sv */
// mock converter with its input selector
// a trigger restarts the conversion at any time, there is no handshake
// valid rises sample_duration + 2 clocks after the trigger edge and
// is held until the next trigger, the reading is latched at that edge

`timescale 1ns/10ps

module adc_mock import az_pkg::*; #(
  parameter int LEVEL_W = az_pkg::LEVEL_W
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      trig,
  input  logic [31:0]               sample_duration,
  input  az_phase_t                 sel,
  input  logic signed [LEVEL_W-1:0] signal_level,
  input  logic signed [LEVEL_W-1:0] zero_level,
  output logic                      valid,
  output adc_reading_t              reading
);

  // width of the value field in the reading
  localparam int READ_W = $bits(adc_reading_t) - $bits(az_phase_t);

  typedef enum logic [1:0]
  {
    A_IDLE = 2'd0,
    A_WAIT = 2'd1,
    A_DONE = 2'd2
  } adc_state_t;

  adc_state_t                state;
  logic [31:0]               count;
  logic signed [LEVEL_W-1:0] level_sel;

  // the selected "analog" input
  assign level_sel = (sel == PHASE_ZERO) ? zero_level : signal_level;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= A_IDLE;
      valid <= 1'b0;
      count <= 32'd0;
    end
    else if (trig)
    begin
      // interrupt whatever is running and start over
      state <= A_WAIT;
      valid <= 1'b0;
      count <= sample_duration;
    end
    else
    begin
      case (state)
        A_WAIT:
        begin
          if (count == 32'd0)
            state <= A_DONE;
          else
            count <= count - 32'd1;
        end

        A_DONE:
        begin
          // measurement complete, valid stays up until the next trigger
          valid <= 1'b1;
          state <= A_IDLE;
        end

        default:
          state <= A_IDLE;
      endcase
    end
  end

  // sample the selected level at completion, tagged with its phase
  always_ff @(posedge clk)
  begin
    if (!trig && state == A_DONE)
    begin
      reading.value <= READ_W'(level_sel);
      reading.phase <= sel;
    end
  end

endmodule

/* logic/az_sequencer.sv */
// auto-zero sequencer, orders the zero and signal phases
// az mode runs zero then signal, raw mode runs signal phases only
// abort restarts from the first phase, which re-triggers the converter
// adc_valid is a held level, so it is only looked at in WAIT

`timescale 1ns/10ps

module az_sequencer import az_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  az_cfg_t   cfg,
  input  logic      run,
  input  logic      abort,
  input  logic      settle_done,
  input  logic      adc_valid,
  output logic      settle_start,
  output logic      adc_trig,
  output az_phase_t phase,
  output logic      reading_take,
  output logic [2:0] state_code
);

  typedef enum logic [2:0]
  {
    S_IDLE    = 3'd0,
    S_SETTLE  = 3'd1,
    S_TRIGGER = 3'd2,
    S_WAIT    = 3'd3,
    S_NEXT    = 3'd4
  } seq_state_t;

  seq_state_t state;
  az_phase_t  first_phase;

  // a pair always starts with the zero reading in az mode
  assign first_phase = cfg.az_enable ? PHASE_ZERO : PHASE_SIGNAL;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= S_IDLE;
      phase        <= PHASE_ZERO;
      settle_start <= 1'b0;
    end
    else
    begin
      // start is a one cycle strobe
      settle_start <= 1'b0;

      if (abort && state != S_IDLE)
      begin
        // back to the first phase, settle again from scratch
        phase        <= first_phase;
        state        <= S_SETTLE;
        settle_start <= 1'b1;
      end
      else
      begin
        case (state)
          S_IDLE:
          begin
            if (run)
            begin
              phase        <= first_phase;
              state        <= S_SETTLE;
              settle_start <= 1'b1;
            end
          end

          S_SETTLE:
          begin
            // a done seen next to a fresh start belongs to the old count
            if (settle_done && !settle_start)
              state <= S_TRIGGER;
          end

          S_TRIGGER:
          begin
            // adc_trig is high for this single cycle
            state <= S_WAIT;
          end

          S_WAIT:
          begin
            if (adc_valid)
              state <= S_NEXT;
          end

          S_NEXT:
          begin
            if (phase == PHASE_ZERO)
            begin
              // zero done, now the signal of the same pair
              phase        <= PHASE_SIGNAL;
              state        <= S_SETTLE;
              settle_start <= 1'b1;
            end
            else if (run)
            begin
              phase        <= first_phase;
              state        <= S_SETTLE;
              settle_start <= 1'b1;
            end
            else
            begin
              state <= S_IDLE;
            end
          end

          default:
            state <= S_IDLE;
        endcase
      end
    end
  end

  // strobes decoded from the state
  assign adc_trig = (state == S_TRIGGER);

  // an abort in the same cycle discards the reading
  assign reading_take = (state == S_WAIT) && adc_valid && !abort;

  assign state_code = state;

endmodule

/* logic/settle_timer.sv */
// settling timer for the input selector
// done pulses in the cycle that ends cycles clocks after start was sampled
// a new start reloads the count, even while running

`timescale 1ns/10ps

module settle_timer (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [15:0] cycles,
  output logic        done
);

  logic [15:0] count;
  logic        running;

  // last cycle of the count
  // also covers a count of zero so the timer can never hang
  assign done = running && (count <= 16'd1);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count   <= 16'd0;
      running <= 1'b0;
    end
    else if (start)
    begin
      // restart from the full settle time
      count   <= cycles;
      running <= 1'b1;
    end
    else if (done)
    begin
      running <= 1'b0;
    end
    else if (running)
    begin
      count <= count - 16'd1;
    end
  end

endmodule

/* logic/az_pkg.sv */
// shared widths and types for the auto-zero front end
// a reading is always tagged with the phase that produced it
// settle_cycles must be at least 1, cfg is held static while run is high

package az_pkg;

  // width of an input level and of a raw reading
  localparam int LEVEL_W = 20;

  // corrected result, wide enough for the difference of two levels
  localparam int RESULT_W = 24;

  // input selector setting, also used as the tag on a reading
  typedef enum logic
  {
    PHASE_ZERO   = 1'b0,
    PHASE_SIGNAL = 1'b1
  } az_phase_t;

  // static configuration
  typedef struct packed
  {
    logic [31:0] sample_duration;
    logic [15:0] settle_cycles;
    logic        az_enable;
  } az_cfg_t;

  // completed conversion from the converter
  typedef struct packed
  {
    logic signed [LEVEL_W-1:0] value;
    az_phase_t                 phase;
  } adc_reading_t;

  // output of the result stage
  // az is set when the value had the zero reading subtracted
  typedef struct packed
  {
    logic signed [RESULT_W-1:0] value;
    logic                       az;
  } az_result_t;

endpackage
